//--- vlog.f
acq_pkg.sv
rs485_frame_rx.sv
repkg_engine.sv
commu_out_fifo.sv
fx_reg_bus.sv
alarm_beep.sv
acq_top.sv
tb_clk_gen.sv
tb_acq_top.sv

//--- tb_acq_top.sv
`timescale 1ns/1ns
// acquisition path testbench: serial frames in, fx bus reads out, checked against a model
module tb_acq_top import acq_pkg::*; ();

	localparam int CLK_NS      = 8;
	localparam int MAX_WORDS   = 20;
	localparam int MAX_BYTES   = 3 + 2 * MAX_WORDS;
	localparam int NUM_FRAMES  = 12;
	localparam int OVF_WORDS   = 20;
	localparam int WATCHDOG_NS = NUM_FRAMES * MAX_BYTES * 10 * BIT_CYCLES * CLK_NS * 2;

	localparam logic [15:0] HEAD_LO_ADDR = {MOD_ID_COMMU, 8'h00};
	localparam logic [15:0] HEAD_HI_ADDR = {MOD_ID_COMMU, 8'h01};
	localparam logic [15:0] FRAMES_ADDR  = {MOD_ID_COMMU, 8'h02};
	localparam logic [15:0] STATUS_ADDR  = {MOD_ID_COMMU, 8'h03};
	localparam logic [15:0] ERRCNT_ADDR  = {MOD_ID_FETCH, 8'h00};
	localparam logic [15:0] ENABLE_ADDR  = {MOD_ID_REPKG, 8'h00};

	logic clk_sys;
	logic rst_n;
	logic rx_line;
	fx_req_t fx_req;
	logic [7:0] fx_q;
	logic arm_int_n;
	logic beep;

	int seed;
	logic [15:0] pay [MAX_WORDS];
	repk_word_u exp_q [$];
	int exp_len_q [$];
	repk_word_u flush_q [$];
	logic drain_en = 1'b0;
	logic checker_busy = 1'b0;
	int word_errs = 0;
	int reg_errs = 0;
	int bit_errs = 0;
	int other_errs = 0;

	tb_clk_gen u_clk (
		.clk_sys (clk_sys),
		.rst_n   (rst_n)
	);

	acq_top dut (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.rx_line   (rx_line),
		.fx_req    (fx_req),
		.fx_q      (fx_q),
		.arm_int_n (arm_int_n),
		.beep      (beep)
	);

	// expected word idx of a frame: header, payload, then trailer
	function automatic repk_word_u repkg_ref(input int n, input logic bad, input int idx);
		repk_word_u w;
		logic [15:0] sum;
		int i;
		w.raw = 16'h0000;
		sum   = 16'h0000;
		if (idx == 0) begin
			w.hdr.mod_id = 6'h34;
			w.hdr.len    = 10'(n);
		end else if (idx <= n) begin
			w.raw = pay[idx-1];
		end else begin
			for (i = 0; i < n; i++)
				sum = sum + pay[i];
			w.raw = {bad, sum[14:0]};
		end
		return w;
	endfunction

	function automatic int rand_words();
		int r;
		r = $random(seed);
		return 1 + ((r & 32'h7fff_ffff) % MAX_WORDS);
	endfunction

	task automatic fill_payload(input int n);
		int i;
		int r;
		for (i = 0; i < n; i++) begin
			r = $random(seed);
			pay[i] = r[15:0];
		end
	endtask

	task automatic expect_frame(input int n, input logic bad);
		int i;
		for (i = 0; i < n + 2; i++)
			exp_q.push_back(repkg_ref(n, bad, i));
		exp_len_q.push_back(n + 2);
	endtask

	task automatic compare_word(input string name, input repk_word_u got, input repk_word_u exp);
		if (got.raw !== exp.raw) begin
			$display("ERROR %0t %s got %h expected %h", $time, name, got.raw, exp.raw);
			word_errs++;
		end
	endtask

	task automatic check_reg(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			$display("ERROR %0t %s got %h expected %h", $time, name, got, exp);
			reg_errs++;
		end
	endtask

	task automatic verify_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("ERROR %0t %s got %b expected %b", $time, name, got, exp);
			bit_errs++;
		end
	endtask

	// all drivers below start and end 1 ns after a rising edge
	task automatic drive_bit(input logic v);
		rx_line = v;
		repeat (BIT_CYCLES) @(posedge clk_sys);
		#1;
	endtask

	task automatic line_idle(input int n_bits);
		repeat (n_bits) drive_bit(1'b1);
	endtask

	// 8N1, lsb first
	task automatic send_byte(input logic [7:0] b, input logic stop);
		int i;
		drive_bit(1'b0);
		for (i = 0; i < 8; i++)
			drive_bit(b[i]);
		drive_bit(stop);
	endtask

	task automatic send_frame(input int n, input logic corrupt);
		logic [7:0] len;
		logic [7:0] chk;
		int i;
		len = 8'(2 * n);
		chk = len;
		send_byte(SYNC_BYTE, 1'b1);
		send_byte(len, 1'b1);
		for (i = 0; i < n; i++) begin
			send_byte(pay[i][7:0], 1'b1);
			send_byte(pay[i][15:8], 1'b1);
			chk = chk ^ pay[i][7:0] ^ pay[i][15:8];
		end
		if (corrupt)
			chk = ~chk;
		send_byte(chk, 1'b1);
	endtask

	task automatic fx_read(input logic [15:0] addr, output logic [7:0] q);
		fx_req.rd    = 1'b1;
		fx_req.raddr = addr;
		@(posedge clk_sys);
		#1;
		fx_req.rd = 1'b0;
		q = fx_q;
	endtask

	task automatic fx_write(input logic [15:0] addr, input logic [7:0] d);
		fx_req.wr    = 1'b1;
		fx_req.waddr = addr;
		fx_req.data  = d;
		@(posedge clk_sys);
		#1;
		fx_req.wr = 1'b0;
	endtask

	// high byte read pops the head
	task automatic read_word(output repk_word_u w);
		logic [7:0] lo;
		logic [7:0] hi;
		fx_read(HEAD_LO_ADDR, lo);
		fx_read(HEAD_HI_ADDR, hi);
		w.raw = {hi, lo};
	endtask

	task automatic drain_frame();
		repk_word_u got;
		int n;
		checker_busy = 1'b1;
		if (exp_len_q.size() == 0) begin
			$display("%0t interrupt raised while no frame was expected", $time);
			other_errs++;
			read_word(got);
			n = got.hdr.len + 1;
			repeat (n) read_word(got);
		end else begin
			n = exp_len_q.pop_front();
			repeat (n) begin
				read_word(got);
				compare_word("fifo word", got, exp_q.pop_front());
			end
		end
		checker_busy = 1'b0;
	endtask

	// lets the compare process run until every expected frame is read
	task automatic wait_drained();
		drain_en = 1'b1;
		do begin
			@(posedge clk_sys);
			#1;
		end while (exp_len_q.size() != 0 || checker_busy);
		drain_en = 1'b0;
		@(posedge clk_sys);
		#1;
		while (checker_busy) begin
			@(posedge clk_sys);
			#1;
		end
	endtask

	// compare process, drains frames while the interrupt is low
	initial begin
		forever begin
			@(posedge clk_sys);
			#1;
			if (drain_en && rst_n && !arm_int_n)
				drain_frame();
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired at %0t, the run did not finish in time", $time);
		$display("TEST FAIL");
		$finish;
	end

	initial begin
		int n;
		int f;
		int i;
		int stored;
		int frame_words;
		logic [7:0] q;
		logic [7:0] exp_err;
		repk_word_u w;
		seed    = 14;
		exp_err = 8'd0;
		rx_line = 1'b1;
		fx_req  = '0;
		wait (rst_n);
		@(posedge clk_sys);
		#1;
		check_reg("fx_q", fx_q, 8'h00);
		verify_bit("arm_int_n", arm_int_n, 1'b1);
		verify_bit("beep", beep, 1'b0);

		// good frames of random length
		repeat (3) begin
			n = rand_words();
			fill_payload(n);
			expect_frame(n, 1'b0);
			send_frame(n, 1'b0);
			wait_drained();
			fx_read(FRAMES_ADDR, q);
			check_reg("frames", q, 8'h00);
		end

		// wrong check byte
		n = rand_words();
		fill_payload(n);
		expect_frame(n, 1'b1);
		send_frame(n, 1'b1);
		wait_drained();
		exp_err = exp_err + 8'd1;
		fx_read(ERRCNT_ADDR, q);
		check_reg("err_count", q, exp_err);
		verify_bit("beep", beep, 1'b1);

		// disabled engine drops the whole frame
		fx_write(ENABLE_ADDR, 8'h00);
		fx_read(ENABLE_ADDR, q);
		check_reg("enable", q, 8'h00);
		n = rand_words();
		fill_payload(n);
		send_frame(n, 1'b0);
		repeat (20) @(posedge clk_sys);
		#1;
		verify_bit("arm_int_n", arm_int_n, 1'b1);
		fx_read(FRAMES_ADDR, q);
		check_reg("frames", q, 8'h00);
		fx_write(ENABLE_ADDR, 8'h01);
		n = rand_words();
		fill_payload(n);
		expect_frame(n, 1'b0);
		send_frame(n, 1'b0);
		wait_drained();

		// overflow with no reads, only whole frames that fit are expected
		while (beep) begin
			@(posedge clk_sys);
			#1;
		end
		stored = 0;
		frame_words = OVF_WORDS + 2;
		for (f = 0; f < 4; f++) begin
			fill_payload(OVF_WORDS);
			if (stored + frame_words <= FIFO_DEPTH) begin
				expect_frame(OVF_WORDS, 1'b0);
			end else begin
				for (i = 0; i < frame_words && stored + i < FIFO_DEPTH; i++)
					flush_q.push_back(repkg_ref(OVF_WORDS, 1'b0, i));
			end
			stored = (stored + frame_words > FIFO_DEPTH) ? FIFO_DEPTH : stored + frame_words;
			send_frame(OVF_WORDS, 1'b0);
		end
		fx_read(STATUS_ADDR, q);
		check_reg("status", q, 8'h01);
		verify_bit("beep", beep, 1'b1);
		fx_write(STATUS_ADDR, 8'h01);
		fx_read(STATUS_ADDR, q);
		check_reg("status", q, 8'h00);
		wait_drained();
		// cut-off frame has no trailer, so it is read out here
		while (flush_q.size() != 0) begin
			read_word(w);
			compare_word("fifo partial word", w, flush_q.pop_front());
		end
		fx_read(FRAMES_ADDR, q);
		check_reg("frames", q, 8'h00);

		// length byte with a low stop bit
		send_byte(SYNC_BYTE, 1'b1);
		send_byte(8'h08, 1'b0);
		line_idle(12);
		n = rand_words();
		fill_payload(n);
		expect_frame(n, 1'b0);
		send_frame(n, 1'b0);
		wait_drained();
		fx_read(ERRCNT_ADDR, q);
		check_reg("err_count", q, exp_err);
		fx_read(FRAMES_ADDR, q);
		check_reg("frames", q, 8'h00);

		$display("error counts: words %0d, registers %0d, signals %0d, other %0d",
			word_errs, reg_errs, bit_errs, other_errs);
		if (word_errs + reg_errs + bit_errs + other_errs == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

//--- tb_clk_gen.sv
`timescale 1ns/1ns
// testbench clock and reset generator, 8 ns period and reset low for 4 cycles
module tb_clk_gen (
	output logic clk_sys,
	output logic rst_n
);

	localparam int HALF_NS    = 4;
	localparam int RST_CYCLES = 4;

	initial begin
		clk_sys = 1'b0;
		forever #HALF_NS clk_sys = ~clk_sys;
	end

	// release just after an edge
	initial begin
		rst_n = 1'b0;
		repeat (RST_CYCLES) @(posedge clk_sys);
		#1;
		rst_n = 1'b1;
	end

endmodule

//--- acq_top.sv
`timescale 1ns/1ns
// acquisition top: rs485 receiver, re-packager, output FIFO, fx bus and beep
module acq_top import acq_pkg::*; (
	input  logic       clk_sys,
	input  logic       rst_n,
	input  logic       rx_line,
	input  fx_req_t    fx_req,
	output logic [7:0] fx_q,
	output logic       arm_int_n,
	output logic       beep
);

	pkg_beat_t rx_beat;
	pkg_beat_t rp_beat;
	logic err_pulse;
	logic ovf_pulse;
	logic [7:0] err_count;
	logic [7:0] frames;
	logic [15:0] head;
	logic ovf;
	logic pop;
	logic ovf_clr;
	logic enable;

	rs485_frame_rx u_rx (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.rx_line   (rx_line),
		.beat      (rx_beat),
		.err_pulse (err_pulse),
		.err_count (err_count)
	);

	repkg_engine u_repkg (
		.clk_sys  (clk_sys),
		.rst_n    (rst_n),
		.in_beat  (rx_beat),
		.enable   (enable),
		.out_beat (rp_beat)
	);

	commu_out_fifo u_fifo (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.in_beat   (rp_beat),
		.pop       (pop),
		.head      (head),
		.frames    (frames),
		.ovf       (ovf),
		.ovf_clr   (ovf_clr),
		.ovf_pulse (ovf_pulse),
		.arm_int_n (arm_int_n)
	);

	fx_reg_bus u_regs (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.req       (fx_req),
		.fx_q      (fx_q),
		.head      (head),
		.frames    (frames),
		.ovf       (ovf),
		.err_count (err_count),
		.pop       (pop),
		.ovf_clr   (ovf_clr),
		.enable    (enable)
	);

	// bad frame or lost word
	alarm_beep u_beep (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.trig    (err_pulse | ovf_pulse),
		.beep    (beep)
	);

endmodule

//--- alarm_beep.sv
`timescale 1ns/1ns
// beep timer, holds beep high for a fixed time after the last trigger
module alarm_beep import acq_pkg::*; (
	input  logic clk_sys,
	input  logic rst_n,
	input  logic trig,
	output logic beep
);

	logic [BEEP_W-1:0] cnt;

	// every trigger restarts the full hold
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n)
			cnt <= '0;
		else if (trig)
			cnt <= BEEP_W'(BEEP_CYCLES);
		else if (cnt != '0)
			cnt <= cnt - 1'b1;
	end

	assign beep = (cnt != '0);

endmodule

//--- fx_reg_bus.sv
`timescale 1ns/1ns
// fx bus register decode: control register, read data steering and strobes
module fx_reg_bus import acq_pkg::*; (
	input  logic        clk_sys,
	input  logic        rst_n,
	input  fx_req_t     req,
	output logic [7:0]  fx_q,
	input  logic [15:0] head,
	input  logic [7:0]  frames,
	input  logic        ovf,
	input  logic [7:0]  err_count,
	output logic        pop,
	output logic        ovf_clr,
	output logic        enable
);

	logic [7:0] rd_byte;

	// reading the head high byte consumes the word
	assign pop     = req.rd && (req.raddr == {MOD_ID_COMMU, 8'h01});
	assign ovf_clr = req.wr && (req.waddr == {MOD_ID_COMMU, 8'h03}) && req.data[0];

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n)
			enable <= 1'b1;
		else if (req.wr && req.waddr == {MOD_ID_REPKG, 8'h00})
			enable <= req.data[0];
	end

	// select by module id, then by offset
	always_comb begin
		rd_byte = 8'h00;
		case (req.raddr[15:8])
			MOD_ID_COMMU: begin
				case (req.raddr[7:0])
					8'h00: rd_byte = head[7:0];
					8'h01: rd_byte = head[15:8];
					8'h02: rd_byte = frames;
					8'h03: rd_byte = {7'd0, ovf};
					default: rd_byte = 8'h00;
				endcase
			end
			MOD_ID_FETCH: begin
				if (req.raddr[7:0] == 8'h00)
					rd_byte = err_count;
			end
			MOD_ID_REPKG: begin
				if (req.raddr[7:0] == 8'h00)
					rd_byte = {7'd0, enable};
			end
			default: rd_byte = 8'h00;
		endcase
	end

	// read data shows up the cycle after rd and holds
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n)
			fx_q <= 8'h00;
		else if (req.rd)
			fx_q <= rd_byte;
	end

endmodule

//--- commu_out_fifo.sv
`timescale 1ns/1ns
// output word FIFO with frame counting, host interrupt and overflow flag
module commu_out_fifo import acq_pkg::*; (
	input  logic        clk_sys,
	input  logic        rst_n,
	input  pkg_beat_t   in_beat,
	input  logic        pop,
	output logic [15:0] head,
	output logic [7:0]  frames,
	output logic        ovf,
	input  logic        ovf_clr,
	output logic        ovf_pulse,
	output logic        arm_int_n
);

	logic [15:0] mem_data [FIFO_DEPTH];
	logic mem_eof [FIFO_DEPTH];
	logic [FIFO_AW-1:0] wr_ptr;
	logic [FIFO_AW-1:0] rd_ptr;
	logic [FIFO_AW:0] count;
	logic full;
	logic empty;
	logic push_ok;
	logic pop_ok;
	logic push_eof;
	logic pop_eof;

	assign full     = (count == (FIFO_AW + 1)'(FIFO_DEPTH));
	assign empty    = (count == '0);
	assign push_ok  = in_beat.vld && !full;
	assign pop_ok   = pop && !empty;
	assign push_eof = push_ok && in_beat.eof;
	assign pop_eof  = pop_ok && mem_eof[rd_ptr];

	// head reads zero when nothing is stored
	assign head      = empty ? 16'h0000 : mem_data[rd_ptr];
	assign arm_int_n = (frames == 8'h00);

	always_ff @(posedge clk_sys) begin
		if (push_ok) begin
			mem_data[wr_ptr] <= in_beat.data;
			mem_eof[wr_ptr]  <= in_beat.eof;
		end
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push_ok)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop_ok)
				rd_ptr <= rd_ptr + 1'b1;
			if (push_ok && !pop_ok)
				count <= count + 1'b1;
			else if (pop_ok && !push_ok)
				count <= count - 1'b1;
		end
	end

	// complete frames, one per stored trailer
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			frames <= 8'd0;
		end else if (push_eof && !pop_eof) begin
			frames <= frames + 8'd1;
		end else if (pop_eof && !push_eof) begin
			frames <= frames - 8'd1;
		end
	end

	// sticky overflow, a new overflow wins over the clear
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			ovf       <= 1'b0;
			ovf_pulse <= 1'b0;
		end else begin
			ovf_pulse <= in_beat.vld && full;
			if (in_beat.vld && full)
				ovf <= 1'b1;
			else if (ovf_clr)
				ovf <= 1'b0;
		end
	end

	a_no_pop_empty: assert property (@(posedge clk_sys) disable iff (!rst_n)
		pop |-> !empty)
		else $error("host popped an empty FIFO");

endmodule

//--- repkg_engine.sv
`timescale 1ns/1ns
// re-packager: prepends the header word, sums the payload, appends the trailer
module repkg_engine import acq_pkg::*; (
	input  logic      clk_sys,
	input  logic      rst_n,
	input  pkg_beat_t in_beat,
	input  logic      enable,
	output pkg_beat_t out_beat
);

	logic in_frame;
	logic drop;
	logic [14:0] sum;
	logic [9:0] word_cnt;
	logic [9:0] exp_len;
	logic payload_in;
	logic trl_bad;
	repk_word_u hdr_w;

	assign payload_in = in_beat.vld && !in_beat.sof && !in_beat.eof;

	// header from the length byte, half of it in words
	always_comb begin
		hdr_w.hdr.mod_id = MOD_ID_REPKG[5:0];
		hdr_w.hdr.len    = {2'b00, in_beat.data[8:1]};
	end

	// words that really came in must match the header count
	assign trl_bad = in_beat.bad || (word_cnt != exp_len);

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			in_frame <= 1'b0;
			drop     <= 1'b0;
			sum      <= 15'd0;
			word_cnt <= 10'd0;
			exp_len  <= 10'd0;
			out_beat <= '0;
		end else begin
			out_beat <= '0;
			if (in_beat.vld && in_beat.sof) begin
				in_frame <= 1'b1;
				// enable only counts at the frame start
				drop     <= !enable;
				sum      <= 15'd0;
				word_cnt <= 10'd0;
				exp_len  <= hdr_w.hdr.len;
				if (enable) begin
					out_beat.vld  <= 1'b1;
					out_beat.sof  <= 1'b1;
					out_beat.data <= hdr_w.raw;
				end
			end else if (payload_in) begin
				sum      <= sum + in_beat.data[14:0];
				word_cnt <= word_cnt + 10'd1;
				if (!drop) begin
					out_beat.vld  <= 1'b1;
					out_beat.data <= in_beat.data;
				end
			end else if (in_beat.vld && in_beat.eof) begin
				in_frame <= 1'b0;
				if (!drop) begin
					out_beat.vld  <= 1'b1;
					out_beat.eof  <= 1'b1;
					out_beat.bad  <= trl_bad;
					out_beat.data <= {trl_bad, sum};
				end
			end
		end
	end

	a_beat_in_frame: assert property (@(posedge clk_sys) disable iff (!rst_n)
		in_beat.vld && !in_beat.sof |-> in_frame)
		else $error("payload or eof beat outside a frame");

endmodule

//--- rs485_frame_rx.sv
`timescale 1ns/1ns
// rs485 frame receiver: 8N1 sampling, frame parsing, xor check and error count
module rs485_frame_rx import acq_pkg::*; (
	input  logic       clk_sys,
	input  logic       rst_n,
	input  logic       rx_line,
	output pkg_beat_t  beat,
	output logic       err_pulse,
	output logic [7:0] err_count
);

	typedef enum logic [1:0] {U_IDLE, U_START, U_DATA, U_STOP} uart_st_t;
	typedef enum logic [1:0] {F_HUNT, F_LEN, F_PAY, F_CHK} frame_st_t;

	logic rx_s1;
	logic rx_s2;
	uart_st_t ust;
	logic [BIT_CNT_W-1:0] tick;
	logic [2:0] bit_idx;
	logic [7:0] shreg;
	logic tick_mid;
	logic tick_end;
	logic byte_ok;
	logic stop_bad;

	frame_st_t fst;
	logic [7:0] len_left;
	logic [7:0] xor_acc;
	logic [7:0] lo_byte;
	logic hi_phase;
	logic len_bad;
	logic chk_bad;

	// line idles high
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			rx_s1 <= 1'b1;
			rx_s2 <= 1'b1;
		end else begin
			rx_s1 <= rx_line;
			rx_s2 <= rx_s1;
		end
	end

	assign tick_mid = (tick == BIT_CNT_W'(BIT_CYCLES / 2 - 1));
	assign tick_end = (tick == BIT_CNT_W'(BIT_CYCLES - 1));
	assign byte_ok  = (ust == U_STOP) && tick_end && rx_s2;
	assign stop_bad = (ust == U_STOP) && tick_end && !rx_s2;

	// bit timing, start checked at mid-bit then one full bit per sample
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			ust     <= U_IDLE;
			tick    <= '0;
			bit_idx <= 3'd0;
		end else begin
			case (ust)
				U_IDLE: begin
					tick <= '0;
					if (!rx_s2)
						ust <= U_START;
				end
				U_START: begin
					if (tick_mid) begin
						tick    <= '0;
						bit_idx <= 3'd0;
						// high at mid-bit is a glitch
						ust     <= rx_s2 ? U_IDLE : U_DATA;
					end else begin
						tick <= tick + 1'b1;
					end
				end
				U_DATA: begin
					if (tick_end) begin
						tick    <= '0;
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7)
							ust <= U_STOP;
					end else begin
						tick <= tick + 1'b1;
					end
				end
				default: begin
					if (tick_end) begin
						tick <= '0;
						ust  <= U_IDLE;
					end else begin
						tick <= tick + 1'b1;
					end
				end
			endcase
		end
	end

	// lsb first
	always_ff @(posedge clk_sys) begin
		if (ust == U_DATA && tick_end)
			shreg <= {rx_s2, shreg[7:1]};
	end

	// low byte of a word waits here for its high byte
	always_ff @(posedge clk_sys) begin
		if (byte_ok && fst == F_PAY && !hi_phase)
			lo_byte <= shreg;
	end

	// xor covers the length byte and the payload
	assign chk_bad = (xor_acc != shreg) || len_bad;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			fst       <= F_HUNT;
			len_left  <= 8'd0;
			xor_acc   <= 8'd0;
			hi_phase  <= 1'b0;
			len_bad   <= 1'b0;
			beat      <= '0;
			err_pulse <= 1'b0;
			err_count <= 8'd0;
		end else begin
			beat      <= '0;
			err_pulse <= 1'b0;
			if (stop_bad) begin
				fst <= F_HUNT;
			end else if (byte_ok) begin
				case (fst)
					F_HUNT: begin
						if (shreg == SYNC_BYTE)
							fst <= F_LEN;
					end
					F_LEN: begin
						beat.vld  <= 1'b1;
						beat.sof  <= 1'b1;
						beat.data <= {8'h00, shreg};
						len_left  <= shreg;
						xor_acc   <= shreg;
						hi_phase  <= 1'b0;
						len_bad   <= (shreg == 8'h00) || shreg[0];
						fst       <= (shreg == 8'h00) ? F_CHK : F_PAY;
					end
					F_PAY: begin
						xor_acc  <= xor_acc ^ shreg;
						len_left <= len_left - 8'd1;
						hi_phase <= !hi_phase;
						if (hi_phase) begin
							beat.vld  <= 1'b1;
							beat.data <= {shreg, lo_byte};
						end
						// a trailing odd byte never forms a word
						if (len_left == 8'd1)
							fst <= F_CHK;
					end
					default: begin
						beat.vld  <= 1'b1;
						beat.eof  <= 1'b1;
						beat.bad  <= chk_bad;
						err_pulse <= chk_bad;
						if (chk_bad && err_count != 8'hFF)
							err_count <= err_count + 8'd1;
						fst <= F_HUNT;
					end
				endcase
			end
		end
	end

	a_sof_eof_excl: assert property (@(posedge clk_sys) disable iff (!rst_n)
		beat.vld |-> !(beat.sof && beat.eof))
		else $error("rx beat with sof and eof together");

endmodule

//--- acq_pkg.sv
// acquisition path shared definitions: bus, stream and header types, ids, timing
package acq_pkg;

	// serial bit timing
	localparam int BIT_CYCLES = 16;
	localparam int BIT_CNT_W  = $clog2(BIT_CYCLES);

	// frame sync value on the rs485 line
	localparam logic [7:0] SYNC_BYTE = 8'hA5;

	// fx bus module ids, upper address byte
	localparam logic [7:0] MOD_ID_COMMU = 8'h32;
	localparam logic [7:0] MOD_ID_FETCH = 8'h33;
	localparam logic [7:0] MOD_ID_REPKG = 8'h34;

	// output word buffer, power of two so pointers wrap by themselves
	localparam int FIFO_DEPTH = 64;
	localparam int FIFO_AW    = $clog2(FIFO_DEPTH);

	// beep hold, short for simulation
	localparam int BEEP_CYCLES = 2000;
	localparam int BEEP_W      = $clog2(BEEP_CYCLES + 1);

	// host request on the fx bus
	typedef struct packed {
		logic [15:0] waddr;
		logic        wr;
		logic [7:0]  data;
		logic        rd;
		logic [15:0] raddr;
	} fx_req_t;

	// one word of the internal stream
	typedef struct packed {
		logic        vld;
		logic        sof;
		logic        eof;
		logic        bad;
		logic [15:0] data;
	} pkg_beat_t;

	// header word fields
	typedef struct packed {
		logic [5:0] mod_id;
		logic [9:0] len;
	} repk_hdr_t;

	// header word, seen as raw data or as fields
	typedef union packed {
		logic [15:0] raw;
		repk_hdr_t   hdr;
	} repk_word_u;

endpackage
